// File: logic/control_output.sv
//==========================================================================
// control word output register
// holds each word stable toward the datapath until it is accepted
//==========================================================================
`timescale 1ns/1ns

module control_output (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  decode_pkg::ctl_word_t i_word,
    input  logic                  i_word_valid,
    output logic                  o_word_ready,
    output decode_pkg::ctl_word_t o_ctl,
    output logic                  o_ctl_valid,
    input  logic                  i_ctl_ready
);

    logic load;

    // take a new word when empty or while the current one leaves
    assign o_word_ready = ~o_ctl_valid | i_ctl_ready;
    assign load         = i_word_valid & o_word_ready;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_ctl_valid <= 1'b0;
        else if (load)
            o_ctl_valid <= 1'b1;
        else if (i_ctl_ready)
            o_ctl_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (load)
            o_ctl <= i_word;
    end

endmodule

// File: logic/decode_defines.svh
//==========================================================================
// decode sequencer widths, status bit positions and opcode values
//==========================================================================
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define DATA_W   8
`define TSTATE_W 3

// status byte bit positions
`define STATUS_C 0
`define STATUS_Z 1
`define STATUS_V 6
`define STATUS_N 7

// implied register ops
`define OP_INX   8'hE8
`define OP_INY   8'hC8
`define OP_DEX   8'hCA
`define OP_DEY   8'h88
`define OP_ASL_A 8'h0A
`define OP_LSR_A 8'h4A
`define OP_ROL_A 8'h2A
`define OP_ROR_A 8'h6A
`define OP_TAX   8'hAA
`define OP_TAY   8'hA8
`define OP_TXA   8'h8A
`define OP_TYA   8'h98
`define OP_TXS   8'h9A
`define OP_TSX   8'hBA

// flag ops and nop
`define OP_CLC   8'h18
`define OP_SEC   8'h38
`define OP_CLI   8'h58
`define OP_SEI   8'h78
`define OP_CLV   8'hB8
`define OP_NOP   8'hEA

// immediate loads and alu ops
`define OP_LDA_I 8'hA9
`define OP_LDX_I 8'hA2
`define OP_LDY_I 8'hA0
`define OP_AND_I 8'h29
`define OP_EOR_I 8'h49
`define OP_ORA_I 8'h09
`define OP_ADC_I 8'h69
`define OP_SBC_I 8'hE9
`define OP_CMP_I 8'hC9
`define OP_CPX_I 8'hE0
`define OP_CPY_I 8'hC0

// conditional branches
`define OP_BCC   8'h90
`define OP_BCS   8'hB0
`define OP_BEQ   8'hF0
`define OP_BNE   8'hD0
`define OP_BMI   8'h30
`define OP_BPL   8'h10
`define OP_BVC   8'h50
`define OP_BVS   8'h70

`endif

// File: logic/decode_pkg.sv
//==========================================================================
// decode sequencer types
// request and control word structs shared by all stages
//==========================================================================
`include "decode_defines.svh"

package decode_pkg;

    typedef logic [`DATA_W-1:0] opcode_t;
    typedef logic [`DATA_W-1:0] status_t;

    typedef enum logic [`TSTATE_W-1:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3
    } tstate_t;

    typedef struct packed {
        opcode_t opcode;
        status_t status;
    } op_req_t;

    // program counter and address bus drivers
    typedef struct packed {
        logic pcl_adl, pch_adh, pcl_pcl, pch_pch;
        logic adl_pcl, adh_pch, i_pc;
        logic adl_abl, adh_abh;
    } addr_ctl_t;

    // register to bus, then bus to register
    typedef struct packed {
        logic x_sb, y_sb, ac_sb, s_sb;
        logic dl_db, pch_db, add_adl, add_sb;
        logic sb_db, sb_x, sb_y, sb_ac, sb_s, sb_adh;
    } xfer_ctl_t;

    // alu input selects and operation
    typedef struct packed {
        logic db_add, db_n_add, adl_add, zero_add, sb_add, carry_in;
        logic sums, ands, eors, ors, srs;
    } alu_ctl_t;

    typedef struct packed {
        logic dbz_z, db7_n, db6_v, acr_c, avr_v, ir5_c, ir5_i;
    } flag_ctl_t;

    typedef struct packed {
        tstate_t   tstate;
        addr_ctl_t addr;
        xfer_ctl_t xfer;
        alu_ctl_t  alu;
        flag_ctl_t flag;
        logic      last;
    } ctl_word_t;

endpackage

// File: logic/decode_rom.sv
//==========================================================================
// decode rom
// maps opcode, timing state, status and last alu carry to one control
// word; the last field flags that the next state is T0
//==========================================================================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_rom (
    input  decode_pkg::opcode_t   i_opcode,
    input  decode_pkg::status_t   i_status,
    input  decode_pkg::tstate_t   i_tstate,
    input  logic                  i_last_acr,
    output decode_pkg::ctl_word_t o_word
);
    import decode_pkg::*;

    logic t0, t1, t2, t3;
    logic g_idx, g_shift, g_load, g_alu, g_arith, g_xfer_nz, g_branch;
    logic taken, t1_taken, t2_br, t3_br, t2_carry, finish;
    logic carry_st;

    assign t0 = (i_tstate == T0);
    assign t1 = (i_tstate == T1);
    assign t2 = (i_tstate == T2);
    assign t3 = (i_tstate == T3);

    // opcode groups
    assign g_idx     = i_opcode inside {`OP_INX, `OP_INY, `OP_DEX, `OP_DEY};
    assign g_shift   = i_opcode inside {`OP_ASL_A, `OP_LSR_A, `OP_ROL_A, `OP_ROR_A};
    assign g_load    = i_opcode inside {`OP_LDA_I, `OP_LDX_I, `OP_LDY_I};
    assign g_arith   = i_opcode inside {`OP_ADC_I, `OP_SBC_I, `OP_CMP_I, `OP_CPX_I,
                                        `OP_CPY_I};
    assign g_alu     = g_arith | (i_opcode inside {`OP_AND_I, `OP_EOR_I, `OP_ORA_I});
    // transfers that update n and z
    assign g_xfer_nz = i_opcode inside {`OP_TAX, `OP_TAY, `OP_TXA, `OP_TYA, `OP_TSX};
    assign g_branch  = i_opcode inside {`OP_BCC, `OP_BCS, `OP_BEQ, `OP_BNE,
                                        `OP_BMI, `OP_BPL, `OP_BVC, `OP_BVS};

    assign carry_st = i_status[`STATUS_C];

    always_comb
    begin
        case (i_opcode)
            `OP_BCC: taken = ~carry_st;
            `OP_BCS: taken = carry_st;
            `OP_BEQ: taken = i_status[`STATUS_Z];
            `OP_BNE: taken = ~i_status[`STATUS_Z];
            `OP_BMI: taken = i_status[`STATUS_N];
            `OP_BPL: taken = ~i_status[`STATUS_N];
            `OP_BVC: taken = ~i_status[`STATUS_V];
            `OP_BVS: taken = i_status[`STATUS_V];
            default: taken = 1'b0;
        endcase
    end

    assign t1_taken = t1 & g_branch & taken;
    assign t2_br    = t2 & g_branch;
    assign t3_br    = t3 & g_branch;
    // offset add crossed a page, so pch needs its own +1
    assign t2_carry = t2_br & i_last_acr;
    // T0 writes back the alu result left by T1
    assign finish   = t0 & (g_idx | g_shift | g_alu);

    always_comb
    begin
        o_word.tstate = i_tstate;
        o_word.last   = ~t0 & ~t1_taken & ~t2_carry;

        // every T0 and T1 presents pc on the address bus
        o_word.addr.pcl_adl = t0 | t1 | t3_br;
        o_word.addr.pch_adh = t0 | t1 | t2_br | t3_br;
        o_word.addr.pcl_pcl = t0 | t1 | t3_br;
        o_word.addr.pch_pch = t0 | t1 | t2_br;
        o_word.addr.adl_pcl = t2_br;
        o_word.addr.adh_pch = t3_br;
        o_word.addr.i_pc    = t0 | (t1 & (g_load | g_alu)) | (t1 & g_branch & ~taken);
        o_word.addr.adl_abl = t0 | t1 | t2_br | t3_br;
        o_word.addr.adh_abh = t0 | t1 | t2_br | t3_br;

        // sources onto sb and db
        o_word.xfer.x_sb    = t1 & (i_opcode inside {`OP_INX, `OP_DEX, `OP_TXA, `OP_TXS,
                                                     `OP_CPX_I});
        o_word.xfer.y_sb    = t1 & (i_opcode inside {`OP_INY, `OP_DEY, `OP_TYA, `OP_CPY_I});
        o_word.xfer.ac_sb   = t1 & (g_shift | (i_opcode inside {`OP_TAX, `OP_TAY})
                                    | (g_alu & ~(i_opcode inside {`OP_CPX_I, `OP_CPY_I})));
        o_word.xfer.s_sb    = t1 & (i_opcode == `OP_TSX);
        o_word.xfer.dl_db   = (t1 & (g_load | g_alu)) | t1_taken;
        o_word.xfer.pch_db  = t2_carry;
        o_word.xfer.add_adl = t2_br;
        o_word.xfer.add_sb  = finish | t3_br;

        // destinations
        o_word.xfer.sb_db   = finish | t1_taken
                              | (t1 & (g_load | g_xfer_nz
                                       | (i_opcode inside {`OP_ASL_A, `OP_ROL_A})));
        o_word.xfer.sb_x    = (t0 & (i_opcode inside {`OP_INX, `OP_DEX}))
                              | (t1 & (i_opcode inside {`OP_LDX_I, `OP_TAX, `OP_TSX}));
        o_word.xfer.sb_y    = (t0 & (i_opcode inside {`OP_INY, `OP_DEY}))
                              | (t1 & (i_opcode inside {`OP_LDY_I, `OP_TAY}));
        o_word.xfer.sb_ac   = (t0 & (g_shift | (i_opcode inside {`OP_AND_I, `OP_EOR_I,
                                                                 `OP_ORA_I, `OP_ADC_I,
                                                                 `OP_SBC_I})))
                              | (t1 & (i_opcode inside {`OP_LDA_I, `OP_TXA, `OP_TYA}));
        o_word.xfer.sb_s    = t1 & (i_opcode == `OP_TXS);
        o_word.xfer.sb_adh  = t3_br;

        // alu inputs; open db reads as ff for dec and inverted for inc
        o_word.alu.db_add   = t2_carry
                              | (t1 & (i_opcode inside {`OP_DEX, `OP_DEY, `OP_ASL_A,
                                                        `OP_ROL_A, `OP_AND_I, `OP_EOR_I,
                                                        `OP_ORA_I, `OP_ADC_I}));
        o_word.alu.db_n_add = t1 & (i_opcode inside {`OP_INX, `OP_INY, `OP_SBC_I,
                                                     `OP_CMP_I, `OP_CPX_I, `OP_CPY_I});
        o_word.alu.adl_add  = t1_taken;
        o_word.alu.zero_add = t2_carry;
        o_word.alu.sb_add   = (t1 & (g_idx | g_shift | g_alu)) | t1_taken;
        o_word.alu.carry_in = t1_taken | t2_carry
                              | (t1 & (i_opcode inside {`OP_INX, `OP_INY, `OP_CMP_I,
                                                        `OP_CPX_I, `OP_CPY_I}))
                              | (t1 & carry_st
                                 & (i_opcode inside {`OP_ADC_I, `OP_ROL_A, `OP_ROR_A}))
                              | (t1 & ~carry_st & (i_opcode == `OP_SBC_I));
        o_word.alu.sums     = t1_taken | t2_carry
                              | (t1 & (g_idx | g_arith
                                       | (i_opcode inside {`OP_ASL_A, `OP_ROL_A})));
        o_word.alu.ands     = t1 & (i_opcode == `OP_AND_I);
        o_word.alu.eors     = t1 & (i_opcode == `OP_EOR_I);
        o_word.alu.ors      = t1 & (i_opcode == `OP_ORA_I);
        o_word.alu.srs      = t1 & (i_opcode inside {`OP_LSR_A, `OP_ROR_A});

        // status flag loads
        o_word.flag.dbz_z   = finish | (t1 & (g_load | g_xfer_nz));
        o_word.flag.db7_n   = finish | (t1 & (g_load | g_xfer_nz));
        // only bit test loads v from db, none of the ops decoded here
        o_word.flag.db6_v   = 1'b0;
        o_word.flag.acr_c   = t1 & (g_shift | g_arith);
        o_word.flag.avr_v   = t1 & (g_arith | (i_opcode == `OP_CLV));
        o_word.flag.ir5_c   = t1 & (i_opcode inside {`OP_CLC, `OP_SEC});
        o_word.flag.ir5_i   = t1 & (i_opcode inside {`OP_CLI, `OP_SEI});
    end

endmodule

// File: logic/decode_top.sv
//==========================================================================
// decode sequencer top
// request latch, sequencer with decode rom, output register
//==========================================================================
`timescale 1ns/1ns

module decode_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  decode_pkg::op_req_t   i_req,
    input  logic                  i_req_valid,
    output logic                  o_req_ready,
    input  logic                  i_acr,
    output decode_pkg::ctl_word_t o_ctl,
    output logic                  o_ctl_valid,
    input  logic                  i_ctl_ready
);
    import decode_pkg::*;

    op_req_t   pend;
    logic      pend_valid;
    logic      pend_ready;
    opcode_t   cur_opcode;
    status_t   cur_status;
    tstate_t   cur_tstate;
    logic      cur_last_acr;
    ctl_word_t rom_word;
    ctl_word_t seq_word;
    logic      seq_valid;
    logic      seq_ready;

    opcode_latch u_latch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_pend       (pend),
        .o_pend_valid (pend_valid),
        .i_pend_ready (pend_ready)
    );

    timing_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_pend       (pend),
        .i_pend_valid (pend_valid),
        .o_pend_ready (pend_ready),
        .i_acr        (i_acr),
        .i_word       (rom_word),
        .o_opcode     (cur_opcode),
        .o_status     (cur_status),
        .o_tstate     (cur_tstate),
        .o_last_acr   (cur_last_acr),
        .o_word       (seq_word),
        .o_word_valid (seq_valid),
        .i_word_ready (seq_ready)
    );

    decode_rom u_rom (
        .i_opcode   (cur_opcode),
        .i_status   (cur_status),
        .i_tstate   (cur_tstate),
        .i_last_acr (cur_last_acr),
        .o_word     (rom_word)
    );

    control_output u_out (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_word       (seq_word),
        .i_word_valid (seq_valid),
        .o_word_ready (seq_ready),
        .o_ctl        (o_ctl),
        .o_ctl_valid  (o_ctl_valid),
        .i_ctl_ready  (i_ctl_ready)
    );

endmodule

// File: logic/opcode_latch.sv
//==========================================================================
// opcode request latch
// one entry buffer so the next opcode waits while the current one runs
//==========================================================================
`timescale 1ns/1ns

module opcode_latch (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  decode_pkg::op_req_t i_req,
    input  logic                i_req_valid,
    output logic                o_req_ready,
    output decode_pkg::op_req_t o_pend,
    output logic                o_pend_valid,
    input  logic                i_pend_ready
);

    logic req_fire;

    // open while empty or while the sequencer drains the slot
    assign o_req_ready = ~o_pend_valid | i_pend_ready;
    assign req_fire    = i_req_valid & o_req_ready;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_pend_valid <= 1'b0;
        else if (req_fire)
            o_pend_valid <= 1'b1;
        else if (i_pend_ready)
            o_pend_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (req_fire)
            o_pend <= i_req;
    end

endmodule

// File: logic/timing_sequencer.sv
//==========================================================================
// timing sequencer
// holds the running opcode, its status snapshot and timing state, and
// steps through the states as the output stage takes each word
//==========================================================================
`timescale 1ns/1ns

module timing_sequencer (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  decode_pkg::op_req_t   i_pend,
    input  logic                  i_pend_valid,
    output logic                  o_pend_ready,
    input  logic                  i_acr,
    input  decode_pkg::ctl_word_t i_word,
    output decode_pkg::opcode_t   o_opcode,
    output decode_pkg::status_t   o_status,
    output decode_pkg::tstate_t   o_tstate,
    output logic                  o_last_acr,
    output decode_pkg::ctl_word_t o_word,
    output logic                  o_word_valid,
    input  logic                  i_word_ready
);
    import decode_pkg::*;

    logic    busy;
    logic    word_load;
    logic    at_t0;
    logic    pend_take;
    tstate_t tstate_q;
    tstate_t tstate_next;

    assign word_load = busy & i_word_ready;
    assign at_t0     = (tstate_q == T0);

    // a new opcode enters when idle or as the T0 word leaves
    assign o_pend_ready = ~busy | (word_load & at_t0);
    assign pend_take    = i_pend_valid & o_pend_ready;

    always_comb
    begin
        case (tstate_q)
            T1:      tstate_next = T2;
            T2:      tstate_next = T3;
            default: tstate_next = T0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy       <= 1'b0;
            tstate_q   <= T0;
            o_last_acr <= 1'b0;
        end
        else
        begin
            if (pend_take)
            begin
                busy     <= 1'b1;
                tstate_q <= T1;
            end
            else if (word_load)
            begin
                if (at_t0)
                    busy <= 1'b0;
                else if (i_word.last)
                    tstate_q <= T0;
                else
                    tstate_q <= tstate_next;
            end
            // alu carry of the word just taken, seen by the rom one state later
            if (word_load)
                o_last_acr <= i_acr;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (pend_take)
        begin
            o_opcode <= i_pend.opcode;
            o_status <= i_pend.status;
        end
    end

    assign o_tstate     = tstate_q;
    assign o_word_valid = busy;

    // rom last means "next state is T0"; downstream last marks the T0 word
    always_comb
    begin
        o_word      = i_word;
        o_word.last = at_t0;
    end

endmodule

// File: tests/decode_assertions.sv
//==========================================================================
// decode sequencer protocol assertions
// output hold under stall, reset state and word order at instruction edges
//==========================================================================
`timescale 1ns/1ns

module decode_assertions (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input decode_pkg::ctl_word_t i_ctl,
    input logic                  i_ctl_valid,
    input logic                  i_ctl_ready,
    input logic                  i_req_ready
);
    import decode_pkg::*;

    int   fail_count = 0;
    logic after_last;

    // set once an instruction's final word has left
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            after_last <= 1'b1;
        else if (i_ctl_valid && i_ctl_ready)
            after_last <= i_ctl.last;
    end

    a_reset_state: assert property (@(posedge i_clk)
        !i_rst_n |=> !i_ctl_valid && i_req_ready)
    else
    begin
        $error("output valid or request ready wrong right after reset");
        fail_count++;
    end

    a_hold_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ctl_valid && !i_ctl_ready |=> i_ctl_valid && $stable(i_ctl))
    else
    begin
        $error("control word changed or dropped while stalled");
        fail_count++;
    end

    a_first_t1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ctl_valid && after_last |-> i_ctl.tstate == T1)
    else
    begin
        $error("first word of an instruction is not T1");
        fail_count++;
    end

endmodule

// File: tests/decode_tb.sv
//==========================================================================
// decode sequencer testbench
// random opcode stream with expected word sequences, random output stalls
//==========================================================================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int CLK_NS      = 8;
    localparam int N_INSTR     = 300;
    localparam int B2B_INSTR   = 40;
    localparam int N_OPS       = 39;
    localparam int WATCHDOG_NS = N_INSTR * 4 * 4 * CLK_NS + 16 * CLK_NS;

    localparam opcode_t KEPT_OPS [N_OPS] = '{
        `OP_INX, `OP_INY, `OP_DEX, `OP_DEY, `OP_ASL_A, `OP_LSR_A, `OP_ROL_A,
        `OP_ROR_A, `OP_TAX, `OP_TAY, `OP_TXA, `OP_TYA, `OP_TXS, `OP_TSX,
        `OP_CLC, `OP_SEC, `OP_CLI, `OP_SEI, `OP_CLV, `OP_NOP,
        `OP_LDA_I, `OP_LDX_I, `OP_LDY_I, `OP_AND_I, `OP_EOR_I, `OP_ORA_I,
        `OP_ADC_I, `OP_SBC_I, `OP_CMP_I, `OP_CPX_I, `OP_CPY_I,
        `OP_BCC, `OP_BCS, `OP_BEQ, `OP_BNE, `OP_BMI, `OP_BPL, `OP_BVC, `OP_BVS
    };

    typedef struct packed {
        logic [15:0] idx;
        tstate_t     tstate;
        logic        last;
    } exp_word_t;

    logic        clk;
    logic        rst_n;
    op_req_t     i_req;
    logic        i_req_valid;
    logic        o_req_ready;
    logic        i_acr;
    ctl_word_t   o_ctl;
    logic        o_ctl_valid;
    logic        i_ctl_ready;

    opcode_t     prog_op [N_INSTR];
    status_t     prog_st [N_INSTR];
    logic        prog_acr [N_INSTR];
    exp_word_t   exp_q [$];
    logic [31:0] rng;
    int          req_idx    = 0;
    int          done_count = 0;
    logic        t0_taken   = 1'b0;

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(3)) u_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    decode_top i_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req       (i_req),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_acr       (i_acr),
        .o_ctl       (o_ctl),
        .o_ctl_valid (o_ctl_valid),
        .i_ctl_ready (i_ctl_ready)
    );

    bind decode_top decode_assertions u_assert (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_ctl       (o_ctl),
        .i_ctl_valid (o_ctl_valid),
        .i_ctl_ready (i_ctl_ready),
        .i_req_ready (o_req_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic branch_taken(input opcode_t op, input status_t st);
        case (op)
            `OP_BCC: return !st[`STATUS_C];
            `OP_BCS: return st[`STATUS_C];
            `OP_BEQ: return st[`STATUS_Z];
            `OP_BNE: return !st[`STATUS_Z];
            `OP_BMI: return st[`STATUS_N];
            `OP_BPL: return !st[`STATUS_N];
            `OP_BVC: return !st[`STATUS_V];
            `OP_BVS: return st[`STATUS_V];
            default: return 1'b0;
        endcase
    endfunction

    // taken branch adds T2, and T3 when the offset add carried
    function automatic int word_count(input opcode_t op, input status_t st, input logic acr);
        if (!branch_taken(op, st))
            return 2;
        else if (acr)
            return 4;
        else
            return 3;
    endfunction

    task automatic build_program();
        int        i;
        int        p;
        int        n;
        exp_word_t e;
        for (i = 0; i < N_INSTR; i++)
        begin
            rng = xorshift32(rng);
            prog_op[i] = KEPT_OPS[rng % N_OPS];
            rng = xorshift32(rng);
            prog_st[i] = rng[7:0];
            rng = xorshift32(rng);
            prog_acr[i] = rng[9];
            n = word_count(prog_op[i], prog_st[i], prog_acr[i]);
            for (p = 0; p < n; p++)
            begin
                e.idx    = i[15:0];
                e.tstate = (p == n - 1) ? T0 : tstate_t'(p + 1);
                e.last   = (p == n - 1);
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    // op_bits as {sums, ands, eors, ors}
    task automatic check_alu(input ctl_word_t w, input logic [3:0] op_bits, input logic cin);
        check_value("o_ctl.alu {sums,ands,eors,ors}",
                    {w.alu.sums, w.alu.ands, w.alu.eors, w.alu.ors}, op_bits);
        check_value("o_ctl.alu.carry_in", w.alu.carry_in, cin);
    endtask

    // register selects as {x, y, ac, s}
    task automatic check_xfer(input ctl_word_t w, input logic [3:0] src,
                              input logic [3:0] dst, input logic nz);
        check_value("o_ctl.xfer {x_sb,y_sb,ac_sb,s_sb}",
                    {w.xfer.x_sb, w.xfer.y_sb, w.xfer.ac_sb, w.xfer.s_sb}, src);
        check_value("o_ctl.xfer {sb_x,sb_y,sb_ac,sb_s}",
                    {w.xfer.sb_x, w.xfer.sb_y, w.xfer.sb_ac, w.xfer.sb_s}, dst);
        check_value("o_ctl.flag {db7_n,dbz_z}", {w.flag.db7_n, w.flag.dbz_z}, {nz, nz});
    endtask

    task automatic check_t1_fields(input ctl_word_t w, input opcode_t op, input status_t st);
        logic c;
        c = st[`STATUS_C];
        case (op)
            `OP_ADC_I: check_alu(w, 4'b1000, c);
            `OP_SBC_I: check_alu(w, 4'b1000, ~c);
            `OP_CMP_I, `OP_CPX_I, `OP_CPY_I, `OP_INX, `OP_INY: check_alu(w, 4'b1000, 1'b1);
            `OP_AND_I: check_alu(w, 4'b0100, 1'b0);
            `OP_EOR_I: check_alu(w, 4'b0010, 1'b0);
            `OP_ORA_I: check_alu(w, 4'b0001, 1'b0);
            `OP_ROL_A, `OP_ROR_A: check_value("o_ctl.alu.carry_in", w.alu.carry_in, c);
            `OP_LDA_I: check_value("o_ctl.xfer.sb_ac", w.xfer.sb_ac, 1'b1);
            `OP_LDX_I: check_value("o_ctl.xfer.sb_x", w.xfer.sb_x, 1'b1);
            `OP_LDY_I: check_value("o_ctl.xfer.sb_y", w.xfer.sb_y, 1'b1);
            `OP_TAX: check_xfer(w, 4'b0010, 4'b1000, 1'b1);
            `OP_TAY: check_xfer(w, 4'b0010, 4'b0100, 1'b1);
            `OP_TXA: check_xfer(w, 4'b1000, 4'b0010, 1'b1);
            `OP_TYA: check_xfer(w, 4'b0100, 4'b0010, 1'b1);
            `OP_TXS: check_xfer(w, 4'b1000, 4'b0001, 1'b0);
            `OP_TSX: check_xfer(w, 4'b0001, 4'b1000, 1'b1);
            default: ;
        endcase
    endtask

    task automatic check_word(input ctl_word_t w);
        exp_word_t e;
        opcode_t   op;
        status_t   st;
        if (exp_q.size() == 0)
            abort_run("control word accepted with no instruction outstanding");
        else
        begin
            e  = exp_q.pop_front();
            op = prog_op[e.idx];
            st = prog_st[e.idx];
            check_value("o_ctl.tstate", w.tstate, e.tstate);
            check_value("o_ctl.last", w.last, e.last);
            if (e.last)
                done_count++;
            if (e.tstate == T1)
                check_t1_fields(w, op, st);
            else if (e.tstate == T0 && (op == `OP_INX || op == `OP_DEX))
                check_value("o_ctl.xfer.sb_x", w.xfer.sb_x, 1'b1);
        end
    endtask

    // request side, valid held until the latch takes it
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (!i_req_valid || o_req_ready)
            begin
                if (req_idx < N_INSTR)
                begin
                    i_req.opcode <= prog_op[req_idx];
                    i_req.status <= prog_st[req_idx];
                    i_req_valid  <= 1'b1;
                    req_idx++;
                end
                else
                    i_req_valid <= 1'b0;
            end
        end
    end

    // output side scoreboard, acr and stall stimulus
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            // next T1 must be right behind each accepted T0
            if (t0_taken && exp_q.size() > 0)
                assert (o_ctl_valid && o_ctl.tstate == T1)
                else abort_run("no T1 word on the cycle after the previous T0 was accepted");
            t0_taken = 1'b0;
            // acr of the following instruction once this T1 has loaded
            if (o_ctl_valid && exp_q.size() > 0 && exp_q[0].tstate == T1
                && exp_q[0].idx + 1 < N_INSTR)
                i_acr <= prog_acr[exp_q[0].idx + 1];
            if (o_ctl_valid && i_ctl_ready)
            begin
                t0_taken = o_ctl.last;
                check_word(o_ctl);
            end
            rng = xorshift32(rng);
            if (done_count < B2B_INSTR)
                i_ctl_ready <= 1'b1;
            else
                i_ctl_ready <= (rng[3:2] != 2'b00);
        end
    end

    always @(posedge clk)
    begin
        if (i_dut.u_assert.fail_count != 0)
            abort_run("a bound protocol assertion failed");
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the control word stream did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial
    begin : main_seq
        i_req       = '0;
        i_req_valid = 1'b0;
        i_ctl_ready = 1'b0;
        rng         = 32'd14;
        build_program();
        i_acr       = prog_acr[0];
        wait (done_count == N_INSTR);
        repeat (4) @(posedge clk);
        if (i_dut.u_assert.fail_count == 0)
        begin
            $display("NO ERRORS");
            $finish;
        end
        else
        begin
            $display("ERRORS FOUND");
            $fatal(1, "bound assertions reported failures");
        end
    end

endmodule

// File: tests/tb_clock.sv
//==========================================================================
// testbench clock and reset generator
// free running clock, active low reset held for a few cycles
//==========================================================================
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: verilog.f
+incdir+logic
logic/decode_pkg.sv
logic/opcode_latch.sv
logic/timing_sequencer.sv
logic/decode_rom.sv
logic/control_output.sv
logic/decode_top.sv
tests/tb_clock.sv
tests/decode_assertions.sv
tests/decode_tb.sv
